// ==== hdl/calcPkg.sv ====
`default_nettype none

package calcPkg;

    // Stack word and the narrower views of it
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;

    // One decimal digit
    typedef logic [3:0] bcd_t;

    // Bit 6 is segment a, bit 0 is segment g, lit when high
    typedef logic [6:0] segments_t;

    typedef logic [7:0] led_t;

    // Core command codes
    typedef enum logic [7:0]
    {
        PushLow = 8'h01,
        Pop     = 8'h02,
        Copy    = 8'h03,
        Add     = 8'h04,
        Sub     = 8'h05,
        Mul     = 8'h06,
        Swap    = 8'h09,
        PushHi  = 8'h21,
        Clear   = 8'h80
    } opcode_t;

    // Button controller states
    typedef enum logic [1:0]
    {
        Idle    = 2'd0,
        Execute = 2'd1,
        Wait    = 2'd2
    } ctrlState_t;

endpackage

`default_nettype wire

// ==== hdl/segmentDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module segmentDecoder
(
    input  wire calcPkg::bcd_t  digit,
    input  wire                 blank,
    output calcPkg::segments_t  segments
);

    always_comb
    begin
        if (blank)
            segments = '0;
        else
        begin
            case (digit)
                4'd0: segments = 7'b1111110;
                4'd1: segments = 7'b0110000;
                4'd2: segments = 7'b1101101;
                4'd3: segments = 7'b1111001;
                4'd4: segments = 7'b0110011;
                4'd5: segments = 7'b1011011;
                4'd6: segments = 7'b1011111;
                4'd7: segments = 7'b1110000;
                4'd8: segments = 7'b1111111;
                4'd9: segments = 7'b1111011;
                // Not a decimal digit
                default: segments = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bcdConverter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcdConverter
(
    input  wire calcPkg::half_t value,
    output calcPkg::bcd_t       digit3,
    output calcPkg::bcd_t       digit2,
    output calcPkg::bcd_t       digit1,
    output calcPkg::bcd_t       digit0
);

    // Four digits only, the carry out of the thousands is dropped
    logic [15:0] bcd;

    always_comb
    begin
        bcd = '0;
        for (int i = 15; i >= 0; i--)
        begin
            for (int d = 0; d < 4; d++)
            begin
                if (bcd[4*d +: 4] >= 4'd5)
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
            end
            bcd = {bcd[14:0], value[i]};
        end
    end

    assign digit3 = bcd[15:12];
    assign digit2 = bcd[11:8];
    assign digit1 = bcd[7:4];
    assign digit0 = bcd[3:0];

endmodule

`default_nettype wire

// ==== hdl/statusDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

module statusDisplay
#(
    parameter int StackAddrWidth = 3
)
(
    input  wire                      Clk,
    input  wire                      rst,
    input  wire calcPkg::word_t      stackFirst,
    input  wire [StackAddrWidth:0]   stackSize,
    input  wire                      stackEmpty,
    input  wire                      opError,
    input  wire                      btnOutputHi,
    output calcPkg::led_t            led,
    output wire calcPkg::segments_t  disp3,
    output wire calcPkg::segments_t  disp2,
    output wire calcPkg::segments_t  disp1,
    output wire calcPkg::segments_t  disp0
);

    calcPkg::half_t shownHalf;
    logic           blank;
    calcPkg::bcd_t  digit3;
    calcPkg::bcd_t  digit2;
    calcPkg::bcd_t  digit1;
    calcPkg::bcd_t  digit0;

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            led   <= '0;
            blank <= 1'b1;
        end
        else
        begin
            // Error on the top LED, depth below it
            led   <= {opError, 7'(stackSize)};
            blank <= stackEmpty;
        end
    end

    always_ff @(posedge Clk)
    begin
        shownHalf <= btnOutputHi ? stackFirst[31:16] : stackFirst[15:0];
    end

    bcdConverter u_bcdConverter
    (
        .value  (shownHalf),
        .digit3 (digit3),
        .digit2 (digit2),
        .digit1 (digit1),
        .digit0 (digit0)
    );

    segmentDecoder u_segDecoder3 (.digit(digit3), .blank(blank), .segments(disp3));
    segmentDecoder u_segDecoder2 (.digit(digit2), .blank(blank), .segments(disp2));
    segmentDecoder u_segDecoder1 (.digit(digit1), .blank(blank), .segments(disp1));
    segmentDecoder u_segDecoder0 (.digit(digit0), .blank(blank), .segments(disp0));

endmodule

`default_nettype wire

// ==== hdl/stackCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module stackCore
#(
    parameter int StackAddrWidth = 3
)
(
    input  wire                        Clk,
    input  wire                        rst,
    input  wire calcPkg::opcode_t      opcode,
    input  wire calcPkg::word_t        operand,
    input  wire                        execute,
    output logic                       done,
    output calcPkg::word_t             stackFirst,
    output logic [StackAddrWidth:0]    stackSize,
    output logic                       stackEmpty,
    output logic                       opError
);

    localparam int Depth = 1 << StackAddrWidth;
    localparam logic [StackAddrWidth:0] DepthCount = (StackAddrWidth + 1)'(Depth);
    localparam logic [StackAddrWidth:0] OneCount = (StackAddrWidth + 1)'(1);

    calcPkg::word_t stackMem [Depth];

    logic [StackAddrWidth-1:0] freeIdx;
    logic [StackAddrWidth-1:0] topIdx;
    logic [StackAddrWidth-1:0] secIdx;
    calcPkg::word_t            first;
    calcPkg::word_t            second;
    logic                      stackFull;
    logic                      hasTwo;

    logic                      wrA;
    logic [StackAddrWidth-1:0] wrAddrA;
    calcPkg::word_t            wrDataA;
    logic                      wrSec;
    calcPkg::word_t            wrDataSec;
    logic [StackAddrWidth:0]   nextSize;
    logic                      fault;
    logic                      clearError;

    // Full stack wraps freeIdx to zero and topIdx to the last slot
    assign freeIdx    = stackSize[StackAddrWidth-1:0];
    assign topIdx     = freeIdx - StackAddrWidth'(1);
    assign secIdx     = freeIdx - StackAddrWidth'(2);
    assign first      = stackMem[topIdx];
    assign second     = stackMem[secIdx];
    assign stackEmpty = (stackSize == '0);
    assign stackFull  = (stackSize == DepthCount);
    assign hasTwo     = (stackSize > OneCount);
    assign stackFirst = stackEmpty ? '0 : first;

    always_comb
    begin
        wrA        = 1'b0;
        wrAddrA    = freeIdx;
        wrDataA    = operand;
        wrSec      = 1'b0;
        wrDataSec  = first;
        nextSize   = stackSize;
        fault      = 1'b0;
        clearError = 1'b0;
        if (execute)
        begin
            case (opcode)
                calcPkg::PushLow, calcPkg::Copy:
                begin
                    if (stackFull || (opcode == calcPkg::Copy && stackEmpty))
                        fault = 1'b1;
                    else
                    begin
                        wrA      = 1'b1;
                        wrDataA  = (opcode == calcPkg::Copy) ? first : operand;
                        nextSize = stackSize + OneCount;
                    end
                end
                calcPkg::PushHi:
                begin
                    fault   = stackEmpty;
                    wrA     = !stackEmpty;
                    wrAddrA = topIdx;
                    wrDataA = {first[23:0], operand[7:0]};
                end
                calcPkg::Pop:
                begin
                    if (stackEmpty)
                        fault = 1'b1;
                    else
                        nextSize = stackSize - OneCount;
                end
                calcPkg::Swap:
                begin
                    fault   = !hasTwo;
                    wrA     = hasTwo;
                    wrAddrA = topIdx;
                    wrDataA = second;
                    wrSec   = hasTwo;
                end
                calcPkg::Add, calcPkg::Sub, calcPkg::Mul:
                begin
                    if (!hasTwo)
                        fault = 1'b1;
                    else
                    begin
                        wrSec    = 1'b1;
                        nextSize = stackSize - OneCount;
                        case (opcode)
                            calcPkg::Add: wrDataSec = second + first;
                            calcPkg::Sub: wrDataSec = second - first;
                            default:      wrDataSec = second * first;
                        endcase
                    end
                end
                calcPkg::Clear:
                begin
                    nextSize   = '0;
                    clearError = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (wrA)
            stackMem[wrAddrA] <= wrDataA;
        if (wrSec)
            stackMem[secIdx] <= wrDataSec;
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            stackSize <= '0;
            opError   <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            stackSize <= nextSize;
            done      <= execute;
            if (clearError)
                opError <= 1'b0;
            else if (fault)
                opError <= 1'b1;
        end
    end

    assert property (@(posedge Clk) disable iff (rst) stackSize <= DepthCount);

endmodule

`default_nettype wire

// ==== hdl/calcController.sv ====
`timescale 1ns/1ps
`default_nettype none

module calcController
(
    input  wire                 Clk,
    input  wire                 rst,
    input  wire calcPkg::byte_t switch,
    input  wire                 btnPushLow,
    input  wire                 btnPushHi,
    input  wire                 btnExecute,
    input  wire                 btnOutputHi,
    input  wire                 done,
    output calcPkg::opcode_t    opcode,
    output calcPkg::word_t      operand,
    output logic                execute
);

    calcPkg::ctrlState_t state;

    logic             cmdValid;
    calcPkg::opcode_t cmdOpcode;
    calcPkg::word_t   cmdOperand;

    // Button priority decode
    always_comb
    begin
        cmdValid   = 1'b1;
        cmdOpcode  = calcPkg::Add;
        cmdOperand = '0;
        if (btnPushLow)
        begin
            cmdOpcode  = calcPkg::PushLow;
            cmdOperand = calcPkg::word_t'(switch);
        end
        else if (btnPushHi)
        begin
            cmdOpcode  = calcPkg::PushHi;
            cmdOperand = calcPkg::word_t'(switch);
        end
        else if (btnExecute && btnOutputHi)
        begin
            cmdOpcode = calcPkg::Clear;
        end
        else if (btnExecute)
        begin
            case (switch[2:0])
                3'b000: cmdOpcode = calcPkg::Add;
                3'b001: cmdOpcode = calcPkg::Sub;
                3'b010: cmdOpcode = calcPkg::Mul;
                3'b101: cmdOpcode = calcPkg::Pop;
                3'b110: cmdOpcode = calcPkg::Copy;
                3'b111: cmdOpcode = calcPkg::Swap;
                // Divide and modulo slots, no divider here
                default: cmdValid = 1'b0;
            endcase
        end
        else
        begin
            cmdValid = 1'b0;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state   <= calcPkg::Idle;
            execute <= 1'b0;
        end
        else
        begin
            case (state)
                calcPkg::Idle:
                begin
                    if (cmdValid)
                    begin
                        state   <= calcPkg::Execute;
                        execute <= 1'b1;
                    end
                end
                calcPkg::Execute:
                begin
                    state   <= calcPkg::Wait;
                    execute <= 1'b0;
                end
                calcPkg::Wait:
                begin
                    if (done)
                        state <= calcPkg::Idle;
                end
                default:
                begin
                    state   <= calcPkg::Idle;
                    execute <= 1'b0;
                end
            endcase
        end
    end

    // Command held stable while the core works on it
    always_ff @(posedge Clk)
    begin
        if (state == calcPkg::Idle && cmdValid)
        begin
            opcode  <= cmdOpcode;
            operand <= cmdOperand;
        end
    end

    assert property (@(posedge Clk) disable iff (rst) execute |=> !execute);

    // Core answers only while a command is in flight
    assert property (@(posedge Clk) disable iff (rst) (state == calcPkg::Idle) |-> !done);

endmodule

`default_nettype wire

// ==== hdl/miniCalc.sv ====
`timescale 1ns/1ps
`default_nettype none

module miniCalc
#(
    parameter int StackAddrWidth = 3
)
(
    input  wire                Clk,
    input  wire                rst,
    input  wire calcPkg::byte_t switch,
    input  wire                btnPushLow,
    input  wire                btnPushHi,
    input  wire                btnExecute,
    input  wire                btnOutputHi,
    output wire calcPkg::led_t  led,
    output wire calcPkg::segments_t disp3,
    output wire calcPkg::segments_t disp2,
    output wire calcPkg::segments_t disp1,
    output wire calcPkg::segments_t disp0
);

    calcPkg::opcode_t          opcode;
    calcPkg::word_t            operand;
    logic                      execute;
    logic                      done;
    calcPkg::word_t            stackFirst;
    logic [StackAddrWidth:0]   stackSize;
    logic                      stackEmpty;
    logic                      opError;

    calcController u_calcController
    (
        .Clk         (Clk),
        .rst         (rst),
        .switch      (switch),
        .btnPushLow  (btnPushLow),
        .btnPushHi   (btnPushHi),
        .btnExecute  (btnExecute),
        .btnOutputHi (btnOutputHi),
        .done        (done),
        .opcode      (opcode),
        .operand     (operand),
        .execute     (execute)
    );

    stackCore #(.StackAddrWidth(StackAddrWidth)) u_stackCore
    (
        .Clk        (Clk),
        .rst        (rst),
        .opcode     (opcode),
        .operand    (operand),
        .execute    (execute),
        .done       (done),
        .stackFirst (stackFirst),
        .stackSize  (stackSize),
        .stackEmpty (stackEmpty),
        .opError    (opError)
    );

    statusDisplay #(.StackAddrWidth(StackAddrWidth)) u_statusDisplay
    (
        .Clk         (Clk),
        .rst         (rst),
        .stackFirst  (stackFirst),
        .stackSize   (stackSize),
        .stackEmpty  (stackEmpty),
        .opError     (opError),
        .btnOutputHi (btnOutputHi),
        .led         (led),
        .disp3       (disp3),
        .disp2       (disp2),
        .disp1       (disp1),
        .disp0       (disp0)
    );

endmodule

`default_nettype wire

// ==== dv/miniCalcTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module miniCalcTb;

    localparam int StackAddrWidth = 3;
    localparam int Depth = 1 << StackAddrWidth;

    localparam logic [1:0] BtnNone = 2'd0;
    localparam logic [1:0] BtnLow  = 2'd1;
    localparam logic [1:0] BtnHi   = 2'd2;
    localparam logic [1:0] BtnExe  = 2'd3;

    localparam int DirectedRows  = 42;
    localparam int RandomSteps   = 12;
    localparam int RandomRows    = 2 + 3 * RandomSteps;
    localparam int TimeoutCycles = 16 + (DirectedRows + RandomRows) * 8 + 200;

    typedef struct packed
    {
        logic [1:0]     btn;
        calcPkg::byte_t sw;
        logic           outHi;
        logic [3:0]     idle;
        calcPkg::led_t  led;
        logic           blank;
        logic [13:0]    value;
    } tableRow_t;

    logic               Clk;
    logic               rst;
    calcPkg::byte_t     switch;
    logic               btnPushLow;
    logic               btnPushHi;
    logic               btnExecute;
    logic               btnOutputHi;
    calcPkg::led_t      led;
    calcPkg::segments_t disp3;
    calcPkg::segments_t disp2;
    calcPkg::segments_t disp1;
    calcPkg::segments_t disp0;

    tableRow_t      rowTable [$];
    calcPkg::word_t model [$];
    logic           modelErr;
    logic [31:0]    randState;
    int             errorCount;
    int             checkCount;
    int             cycleCount;

    miniCalc #(.StackAddrWidth(StackAddrWidth)) i_miniCalc
    (
        .Clk         (Clk),
        .rst         (rst),
        .switch      (switch),
        .btnPushLow  (btnPushLow),
        .btnPushHi   (btnPushHi),
        .btnExecute  (btnExecute),
        .btnOutputHi (btnOutputHi),
        .led         (led),
        .disp3       (disp3),
        .disp2       (disp2),
        .disp1       (disp1),
        .disp0       (disp0)
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Segment a sits in bit 6
    function automatic calcPkg::segments_t segmentsFor(input calcPkg::bcd_t digit);
        case (digit)
            4'd0: return 7'b1111110;
            4'd1: return 7'b0110000;
            4'd2: return 7'b1101101;
            4'd3: return 7'b1111001;
            4'd4: return 7'b0110011;
            4'd5: return 7'b1011011;
            4'd6: return 7'b1011111;
            4'd7: return 7'b1110000;
            4'd8: return 7'b1111111;
            4'd9: return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic calcPkg::segments_t expectedSegments(input logic blank, input int value,
                                                           input int place);
        int divisor;
        divisor = 1;
        repeat (place) divisor = divisor * 10;
        if (blank)
            return '0;
        return segmentsFor(calcPkg::bcd_t'((value / divisor) % 10));
    endfunction

    function automatic tableRow_t makeRow(input logic [1:0] btn, input calcPkg::byte_t sw,
                                          input logic outHi, input int idle,
                                          input calcPkg::led_t ledExp, input logic blankExp,
                                          input int valueExp);
        tableRow_t r;
        r.btn   = btn;
        r.sw    = sw;
        r.outHi = outHi;
        r.idle  = 4'(idle);
        r.led   = ledExp;
        r.blank = blankExp;
        r.value = 14'(valueExp);
        return r;
    endfunction

    task automatic checkLed(input calcPkg::led_t actual, input calcPkg::led_t expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED at %0t: led is %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic checkDigit(input calcPkg::segments_t actual,
                              input calcPkg::segments_t expected, input int index);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED at %0t: disp%0d is %b, expected %b",
                     $time, index, actual, expected);
        end
    endtask

    task automatic checkOutputs(input calcPkg::led_t expLed, input logic expBlank,
                                input int expValue);
        checkLed(led, expLed);
        checkDigit(disp0, expectedSegments(expBlank, expValue, 0), 0);
        checkDigit(disp1, expectedSegments(expBlank, expValue, 1), 1);
        checkDigit(disp2, expectedSegments(expBlank, expValue, 2), 2);
        checkDigit(disp3, expectedSegments(expBlank, expValue, 3), 3);
    endtask

    // Reference stack with the top word at the queue end
    task automatic updateModel(input logic [1:0] btn, input calcPkg::byte_t sw,
                               input logic outHi);
        calcPkg::word_t first;
        calcPkg::word_t second;
        int last;
        last = model.size() - 1;
        if (btn == BtnLow)
        begin
            if (model.size() == Depth)
                modelErr = 1'b1;
            else
                model.push_back(calcPkg::word_t'(sw));
        end
        else if (btn == BtnHi)
        begin
            if (model.size() == 0)
                modelErr = 1'b1;
            else
            begin
                first = model[last];
                model[last] = {first[23:0], sw};
            end
        end
        else if (btn == BtnExe && outHi)
        begin
            model.delete();
            modelErr = 1'b0;
        end
        else if (btn == BtnExe)
        begin
            case (sw[2:0])
                3'b000, 3'b001, 3'b010, 3'b111:
                begin
                    if (model.size() < 2)
                        modelErr = 1'b1;
                    else
                    begin
                        first  = model.pop_back();
                        second = model.pop_back();
                        case (sw[2:0])
                            3'b000: model.push_back(second + first);
                            3'b001: model.push_back(second - first);
                            3'b010: model.push_back(second * first);
                            default:
                            begin
                                model.push_back(first);
                                model.push_back(second);
                            end
                        endcase
                    end
                end
                3'b101:
                begin
                    if (model.size() == 0)
                        modelErr = 1'b1;
                    else
                        void'(model.pop_back());
                end
                3'b110:
                begin
                    if (model.size() == 0 || model.size() == Depth)
                        modelErr = 1'b1;
                    else
                        model.push_back(model[last]);
                end
                default: ;
            endcase
        end
    endtask

    task automatic modelExpected(input logic outHi, output calcPkg::led_t expLed,
                                 output logic expBlank, output int expValue);
        calcPkg::word_t first;
        calcPkg::half_t half;
        expLed   = {modelErr, 7'(model.size())};
        expBlank = (model.size() == 0);
        expValue = 0;
        if (!expBlank)
        begin
            first    = model[model.size() - 1];
            half     = outHi ? first[31:16] : first[15:0];
            expValue = int'(half) % 10000;
        end
    endtask

    // Button held one cycle and released for the idle cycles
    task automatic runRow(input logic [1:0] btn, input calcPkg::byte_t sw, input logic outHi,
                          input int idle);
        switch      = sw;
        btnOutputHi = outHi;
        btnPushLow  = (btn == BtnLow);
        btnPushHi   = (btn == BtnHi);
        btnExecute  = (btn == BtnExe);
        @(posedge Clk);
        #1;
        btnPushLow = 1'b0;
        btnPushHi  = 1'b0;
        btnExecute = 1'b0;
        repeat (idle) @(posedge Clk);
        #1;
        updateModel(btn, sw, outHi);
    endtask

    task automatic runAndCheckModel(input logic [1:0] btn, input calcPkg::byte_t sw,
                                    input logic outHi);
        calcPkg::led_t expLed;
        logic expBlank;
        int expValue;
        runRow(btn, sw, outHi, 3);
        modelExpected(outHi, expLed, expBlank, expValue);
        checkOutputs(expLed, expBlank, expValue);
    endtask

    task automatic fillTable();
        rowTable.push_back(makeRow(BtnLow,  8'd12,  1'b0, 3, 8'h01, 1'b0, 12));
        rowTable.push_back(makeRow(BtnLow,  8'd34,  1'b0, 3, 8'h02, 1'b0, 34));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b0, 3, 8'h01, 1'b0, 46));
        rowTable.push_back(makeRow(BtnLow,  8'd100, 1'b0, 3, 8'h02, 1'b0, 100));
        // 46 minus 100 wraps to FFFFFFCA
        rowTable.push_back(makeRow(BtnExe,  8'h01,  1'b0, 3, 8'h01, 1'b0, 5482));
        rowTable.push_back(makeRow(BtnNone, 8'h00,  1'b1, 3, 8'h01, 1'b0, 5535));
        rowTable.push_back(makeRow(BtnLow,  8'd25,  1'b0, 3, 8'h02, 1'b0, 25));
        rowTable.push_back(makeRow(BtnExe,  8'h02,  1'b0, 3, 8'h01, 1'b0, 4186));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b1, 3, 8'h00, 1'b1, 0));
        // Build 3456789A one byte at a time
        rowTable.push_back(makeRow(BtnLow,  8'h12,  1'b0, 3, 8'h01, 1'b0, 18));
        rowTable.push_back(makeRow(BtnHi,   8'h34,  1'b0, 3, 8'h01, 1'b0, 4660));
        rowTable.push_back(makeRow(BtnHi,   8'h56,  1'b0, 3, 8'h01, 1'b0, 3398));
        rowTable.push_back(makeRow(BtnHi,   8'h78,  1'b0, 3, 8'h01, 1'b0, 2136));
        rowTable.push_back(makeRow(BtnNone, 8'h00,  1'b1, 3, 8'h01, 1'b0, 4660));
        rowTable.push_back(makeRow(BtnHi,   8'h9A,  1'b1, 3, 8'h01, 1'b0, 3398));
        rowTable.push_back(makeRow(BtnNone, 8'h00,  1'b0, 3, 8'h01, 1'b0, 874));
        rowTable.push_back(makeRow(BtnLow,  8'd5,   1'b0, 3, 8'h02, 1'b0, 5));
        rowTable.push_back(makeRow(BtnExe,  8'h06,  1'b0, 3, 8'h03, 1'b0, 5));
        rowTable.push_back(makeRow(BtnLow,  8'd7,   1'b0, 3, 8'h04, 1'b0, 7));
        rowTable.push_back(makeRow(BtnExe,  8'h07,  1'b0, 3, 8'h04, 1'b0, 5));
        rowTable.push_back(makeRow(BtnExe,  8'h05,  1'b0, 3, 8'h03, 1'b0, 7));
        rowTable.push_back(makeRow(BtnExe,  8'h03,  1'b0, 5, 8'h03, 1'b0, 7));
        rowTable.push_back(makeRow(BtnExe,  8'h04,  1'b0, 3, 8'h03, 1'b0, 7));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b0, 3, 8'h02, 1'b0, 12));
        // Error cases
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b1, 3, 8'h00, 1'b1, 0));
        rowTable.push_back(makeRow(BtnExe,  8'h05,  1'b0, 3, 8'h80, 1'b1, 0));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b1, 3, 8'h00, 1'b1, 0));
        // Fill to the full depth with the error still clear
        rowTable.push_back(makeRow(BtnLow,  8'd9,   1'b0, 3, 8'h01, 1'b0, 9));
        rowTable.push_back(makeRow(BtnLow,  8'd1,   1'b0, 3, 8'h02, 1'b0, 1));
        rowTable.push_back(makeRow(BtnLow,  8'd2,   1'b0, 3, 8'h03, 1'b0, 2));
        rowTable.push_back(makeRow(BtnLow,  8'd3,   1'b0, 3, 8'h04, 1'b0, 3));
        rowTable.push_back(makeRow(BtnLow,  8'd4,   1'b0, 3, 8'h05, 1'b0, 4));
        rowTable.push_back(makeRow(BtnLow,  8'd5,   1'b0, 3, 8'h06, 1'b0, 5));
        rowTable.push_back(makeRow(BtnLow,  8'd6,   1'b0, 3, 8'h07, 1'b0, 6));
        rowTable.push_back(makeRow(BtnLow,  8'd7,   1'b0, 3, 8'h08, 1'b0, 7));
        rowTable.push_back(makeRow(BtnLow,  8'd99,  1'b0, 3, 8'h88, 1'b0, 7));
        rowTable.push_back(makeRow(BtnExe,  8'h06,  1'b0, 3, 8'h88, 1'b0, 7));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b1, 3, 8'h00, 1'b1, 0));
        rowTable.push_back(makeRow(BtnLow,  8'd9,   1'b0, 3, 8'h01, 1'b0, 9));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b0, 3, 8'h81, 1'b0, 9));
        rowTable.push_back(makeRow(BtnLow,  8'd5,   1'b0, 3, 8'h82, 1'b0, 5));
        rowTable.push_back(makeRow(BtnExe,  8'h00,  1'b1, 3, 8'h00, 1'b1, 0));
    endtask

    initial
    begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles)
        begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        tableRow_t row;
        calcPkg::led_t expLed;
        logic expBlank;
        int expValue;
        rst         = 1'b1;
        switch      = '0;
        btnPushLow  = 1'b0;
        btnPushHi   = 1'b0;
        btnExecute  = 1'b0;
        btnOutputHi = 1'b0;
        modelErr    = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        randState   = 32'hecec4363;
        fillTable();
        repeat (16) @(posedge Clk);
        #1;
        rst = 1'b0;
        checkOutputs(8'h00, 1'b1, 0);

        for (int i = 0; i < rowTable.size(); i++)
        begin
            row = rowTable[i];
            runRow(row.btn, row.sw, row.outHi, int'(row.idle));
            modelExpected(row.outHi, expLed, expBlank, expValue);
            if (expLed !== row.led || expBlank !== row.blank || expValue != int'(row.value))
            begin
                errorCount++;
                $display("Reference model disagrees with table row %0d", i);
            end
            checkOutputs(row.led, row.blank, int'(row.value));
        end

        // Random bytes through Add and Mul
        runAndCheckModel(BtnExe, 8'h00, 1'b1);
        randState = xorshift32(randState);
        runAndCheckModel(BtnLow, randState[7:0], 1'b0);
        for (int n = 0; n < RandomSteps; n++)
        begin
            randState = xorshift32(randState);
            runAndCheckModel(BtnLow, randState[7:0], 1'b0);
            randState = xorshift32(randState);
            runAndCheckModel(BtnExe, {randState[15:11], 1'b0, randState[0], 1'b0}, 1'b0);
            runAndCheckModel(BtnNone, 8'h00, randState[4]);
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/calcPkg.sv
hdl/segmentDecoder.sv
hdl/bcdConverter.sv
hdl/statusDisplay.sv
hdl/stackCore.sv
hdl/calcController.sv
hdl/miniCalc.sv
dv/miniCalcTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= miniCalcTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
